// File: hw/lcd_pkg.sv
// ----------------------------------------
// Shared types and tables for the RGB LCD driver
// Panel decode, controller states, per-panel timing and pixel-clock divide
// ----------------------------------------
package lcd_pkg;

    // Supported panels
    typedef enum logic [2:0] {
        PANEL_4342,
        PANEL_7084,
        PANEL_7016,
        PANEL_1018,
        PANEL_4384
    } panel_e;

    // Startup controller states
    typedef enum logic [1:0] {
        ST_SETTLE,
        ST_SAMPLE,
        ST_PANEL_RST,
        ST_RUN
    } ctrl_state_e;

    // Clocks from reset release to strap sampling
    localparam logic [31:0] ID_SETTLE_CYCLES = 32'd16;
    // Clocks of panel reset after the sample
    localparam logic [31:0] PANEL_RST_CYCLES = 32'd64;

    // Strap pin positions on the colour bus, code MSB first
    localparam int STRAP_BITS [0:2] = '{4, 10, 15};

    // ----------------------------------------
    // Strap decode
    // ----------------------------------------

    // Code bit 2 from bus bit 4, bit 0 from bus bit 15
    function automatic logic [2:0] strap_code(logic [15:0] bus);
        return {bus[STRAP_BITS[0]], bus[STRAP_BITS[1]], bus[STRAP_BITS[2]]};
    endfunction

    function automatic panel_e panel_from_code(logic [2:0] code);
        case (code)
            3'd1:    return PANEL_7084;
            3'd2:    return PANEL_7016;
            3'd4:    return PANEL_4384;
            3'd5:    return PANEL_1018;
            // Unlisted codes fall back to the small panel
            default: return PANEL_4342;
        endcase
    endfunction

    // 16-bit ID reported for each panel
    function automatic logic [15:0] panel_id(panel_e p);
        case (p)
            PANEL_7084: return 16'h7084;
            PANEL_7016: return 16'h7016;
            PANEL_1018: return 16'h1018;
            PANEL_4384: return 16'h4384;
            default:    return 16'h4342;
        endcase
    endfunction

    // ----------------------------------------
    // Timing and divider tables
    // ----------------------------------------

    typedef struct packed {
        logic [10:0] h_sync;
        logic [10:0] h_bp;
        logic [10:0] h_act;
        logic [10:0] h_fp;
        logic [10:0] h_total;
        logic [10:0] v_sync;
        logic [10:0] v_bp;
        logic [10:0] v_act;
        logic [10:0] v_fp;
        logic [10:0] v_total;
    } panel_timing_t;

    // Builds one table entry, totals are the sum of the four phases
    function automatic panel_timing_t mk_timing(int hs, int hb, int ha, int hf,
                                                int vs, int vb, int va, int vf);
        panel_timing_t t;
        t.h_sync  = 11'(hs);
        t.h_bp    = 11'(hb);
        t.h_act   = 11'(ha);
        t.h_fp    = 11'(hf);
        t.h_total = 11'(hs + hb + ha + hf);
        t.v_sync  = 11'(vs);
        t.v_bp    = 11'(vb);
        t.v_act   = 11'(va);
        t.v_fp    = 11'(vf);
        t.v_total = 11'(vs + vb + va + vf);
        return t;
    endfunction

    function automatic panel_timing_t panel_timing(panel_e p);
        case (p)
            PANEL_7084: return mk_timing(128, 88, 800, 40, 2, 33, 480, 10);
            PANEL_7016: return mk_timing(20, 140, 1024, 160, 3, 20, 600, 12);
            PANEL_1018: return mk_timing(10, 80, 1280, 70, 3, 10, 800, 10);
            PANEL_4384: return mk_timing(128, 88, 800, 40, 2, 33, 480, 10);
            // 4.3 inch 480x272
            default:    return mk_timing(41, 2, 480, 2, 10, 2, 272, 4);
        endcase
    endfunction

    // Pixel clock divide ratio, never below 2
    function automatic logic [3:0] panel_div(panel_e p);
        case (p)
            PANEL_4342: return 4'd4;
            default:    return 4'd2;
        endcase
    endfunction

endpackage

// File: hw/lcd_ctrl.sv
// ----------------------------------------
// Startup sequencer for the LCD panel
// Strap sampling, panel reset, then video and backlight on
// ----------------------------------------
`timescale 1ns/1ps

module lcd_ctrl (
    input  logic clk,
    input  logic rst_n,
    output logic sample_id,
    output logic run,
    output logic lcd_rst,
    output logic lcd_bl
);

    lcd_pkg::ctrl_state_e state;
    // Shared wait counter, settle first and then panel reset
    logic [31:0]          wait_cnt;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= lcd_pkg::ST_SETTLE;
            wait_cnt <= lcd_pkg::ID_SETTLE_CYCLES - 32'd1;
        end else begin
            case (state)
                lcd_pkg::ST_SETTLE: begin
                    // Bus released, let the straps settle
                    if (wait_cnt == 32'd0) begin
                        state    <= lcd_pkg::ST_SAMPLE;
                        wait_cnt <= lcd_pkg::PANEL_RST_CYCLES - 32'd1;
                    end else begin
                        wait_cnt <= wait_cnt - 32'd1;
                    end
                end
                lcd_pkg::ST_SAMPLE: begin
                    // Single sample cycle counts towards the reset wait
                    state    <= lcd_pkg::ST_PANEL_RST;
                    wait_cnt <= wait_cnt - 32'd1;
                end
                lcd_pkg::ST_PANEL_RST: begin
                    if (wait_cnt == 32'd0) begin
                        state <= lcd_pkg::ST_RUN;
                    end else begin
                        wait_cnt <= wait_cnt - 32'd1;
                    end
                end
                default: begin
                    // Stays in run until the next reset
                    state <= lcd_pkg::ST_RUN;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Outputs decoded from state
    // ----------------------------------------
    assign sample_id = (state == lcd_pkg::ST_SAMPLE);
    assign run       = (state == lcd_pkg::ST_RUN);
    // Panel leaves reset together with video start
    assign lcd_rst   = run;
    assign lcd_bl    = run;

endmodule

// File: hw/lcd_id_reader.sv
// ----------------------------------------
// Panel strap reader
// Samples the strap pins once and holds panel type and ID
// ----------------------------------------
`timescale 1ns/1ps

module lcd_id_reader (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sample_id,
    input  logic [15:0]     lcd_rgb_in,
    output lcd_pkg::panel_e panel,
    output logic [15:0]     id_lcd
);

    logic [2:0]      code;
    lcd_pkg::panel_e panel_dec;

    // Decode straps straight off the bus
    assign code      = lcd_pkg::strap_code(lcd_rgb_in);
    assign panel_dec = lcd_pkg::panel_from_code(code);

    // ----------------------------------------
    // Capture on the sample pulse only
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Small panel and no ID until sampled
            panel  <= lcd_pkg::PANEL_4342;
            id_lcd <= 16'h0000;
        end else if (sample_id) begin
            panel  <= panel_dec;
            id_lcd <= lcd_pkg::panel_id(panel_dec);
        end
    end

endmodule

// File: hw/lcd_pclk_gen.sv
// ----------------------------------------
// Pixel clock generator
// Per-panel divide of clk into an enable strobe and the pclk pin
// ----------------------------------------
`timescale 1ns/1ps

module lcd_pclk_gen (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            run,
    input  lcd_pkg::panel_e panel,
    output logic            pclk_en,
    output logic            lcd_pclk
);

    logic [3:0] div;
    logic [3:0] div_cnt;

    assign div = lcd_pkg::panel_div(panel);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= 4'd0;
            pclk_en  <= 1'b0;
            lcd_pclk <= 1'b0;
        end else if (!run) begin
            // Idle until video starts
            div_cnt  <= 4'd0;
            pclk_en  <= 1'b0;
            lcd_pclk <= 1'b0;
        end else begin
            // Strobe at count zero, one clk after run
            pclk_en  <= (div_cnt == 4'd0);
            // High for the first half period, rounded down
            lcd_pclk <= (div_cnt < (div >> 1));
            if (div_cnt == div - 4'd1) begin
                div_cnt <= 4'd0;
            end else begin
                div_cnt <= div_cnt + 4'd1;
            end
        end
    end

endmodule

// File: hw/lcd_timing.sv
// ----------------------------------------
// Sync and blanking generator
// Line and frame counters advanced by the pixel clock enable
// ----------------------------------------
`timescale 1ns/1ps

module lcd_timing #(
    parameter int POS_W = 11
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             run,
    input  logic             pclk_en,
    input  lcd_pkg::panel_e  panel,
    output logic             lcd_hs,
    output logic             lcd_vs,
    output logic             lcd_de,
    output logic             data_req,
    output logic [POS_W-1:0] pixel_xpos,
    output logic [POS_W-1:0] pixel_ypos
);

    lcd_pkg::panel_timing_t tm;

    // Table values at counter width
    logic [POS_W-1:0] h_total;
    logic [POS_W-1:0] h_sync;
    logic [POS_W-1:0] h_start;
    logic [POS_W-1:0] h_end;
    logic [POS_W-1:0] v_total;
    logic [POS_W-1:0] v_sync;
    logic [POS_W-1:0] v_start;
    logic [POS_W-1:0] v_end;

    logic [POS_W-1:0] h_cnt;
    logic [POS_W-1:0] v_cnt;
    logic             adv;
    logic             h_last;
    logic             v_last;
    logic             h_act;
    logic             h_req;
    logic             v_act;

    assign tm      = lcd_pkg::panel_timing(panel);
    assign h_total = POS_W'(tm.h_total);
    assign h_sync  = POS_W'(tm.h_sync);
    // Active window starts after sync plus back porch
    assign h_start = POS_W'(tm.h_sync + tm.h_bp);
    assign h_end   = h_start + POS_W'(tm.h_act);
    assign v_total = POS_W'(tm.v_total);
    assign v_sync  = POS_W'(tm.v_sync);
    assign v_start = POS_W'(tm.v_sync + tm.v_bp);
    assign v_end   = v_start + POS_W'(tm.v_act);

    assign adv    = run && pclk_en;
    assign h_last = (h_cnt == h_total - 1'b1);
    assign v_last = (v_cnt == v_total - 1'b1);
    assign h_act  = (h_cnt >= h_start) && (h_cnt < h_end);
    // Request window leads the active window by one pixel
    assign h_req  = (h_cnt >= h_start - 1'b1) && (h_cnt < h_end - 1'b1);
    assign v_act  = (v_cnt >= v_start) && (v_cnt < v_end);

    // ----------------------------------------
    // Line and frame counters
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (adv) begin
            if (h_last) begin
                h_cnt <= '0;
                // Frame wraps on the last pixel of the last line
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Registered sync, enable and request
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_hs     <= 1'b1;
            lcd_vs     <= 1'b1;
            lcd_de     <= 1'b0;
            data_req   <= 1'b0;
            pixel_xpos <= '0;
            pixel_ypos <= '0;
        end else if (adv) begin
            // Syncs active low
            lcd_hs   <= (h_cnt >= h_sync);
            lcd_vs   <= (v_cnt >= v_sync);
            lcd_de   <= h_act && v_act;
            data_req <= h_req && v_act;
            // Positions only valid with the request
            if (h_req && v_act) begin
                pixel_xpos <= h_cnt - (h_start - 1'b1);
                pixel_ypos <= v_cnt - v_start;
            end else begin
                pixel_xpos <= '0;
                pixel_ypos <= '0;
            end
        end
    end

endmodule

// File: hw/lcd_pixel_path.sv
// ----------------------------------------
// Pixel path to the colour bus
// Pre-processing tap out, post-processed pixel registered onto the pins
// ----------------------------------------
`timescale 1ns/1ps

module lcd_pixel_path #(
    parameter int PIXEL_W = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               pclk_en,
    input  logic               lcd_de,
    input  logic [PIXEL_W-1:0] pixel_data,
    input  logic [PIXEL_W-1:0] post_rgb,
    input  logic               post_de,
    output logic [PIXEL_W-1:0] pre_rgb,
    output logic [PIXEL_W-1:0] lcd_rgb_out,
    output logic               lcd_rgb_oe
);

    // Tap towards the user processing
    assign pre_rgb = lcd_de ? pixel_data : '0;

    // Pixel register, blanked outside post_de
    always_ff @(posedge clk) begin
        if (pclk_en) begin
            lcd_rgb_out <= post_de ? post_rgb : '0;
        end
    end

    // ----------------------------------------
    // Bus direction
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lcd_rgb_oe <= 1'b0;
        end else if (!run) begin
            // Released while the straps are read
            lcd_rgb_oe <= 1'b0;
        end else if (pclk_en) begin
            lcd_rgb_oe <= post_de;
        end
    end

endmodule

// File: hw/lcd.sv
// ----------------------------------------
// RGB LCD driver top level
// Startup control plus ID, pixel clock, timing and pixel path
// ----------------------------------------
`timescale 1ns/1ps

module lcd #(
    parameter int PIXEL_W = 16,
    parameter int POS_W   = 11
) (
    input  logic               clk,
    input  logic               rst_n,
    // Panel pins
    input  logic [15:0]        lcd_rgb_in,
    output logic               lcd_hs,
    output logic               lcd_vs,
    output logic               lcd_de,
    output logic               lcd_bl,
    output logic               lcd_rst,
    output logic               lcd_pclk,
    output logic [PIXEL_W-1:0] lcd_rgb_out,
    output logic               lcd_rgb_oe,
    output logic [15:0]        id_lcd,
    // User side
    input  logic [PIXEL_W-1:0] pixel_data,
    output logic [PIXEL_W-1:0] pre_rgb,
    input  logic [PIXEL_W-1:0] post_rgb,
    input  logic               post_de,
    output logic               data_req,
    output logic [POS_W-1:0]   pixel_xpos,
    output logic [POS_W-1:0]   pixel_ypos
);

    logic            sample_id;
    logic            run;
    logic            pclk_en;
    lcd_pkg::panel_e panel;

    // Startup sequence
    lcd_ctrl u_lcd_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_id (sample_id),
        .run       (run),
        .lcd_rst   (lcd_rst),
        .lcd_bl    (lcd_bl)
    );

    // Strap pins to panel type
    lcd_id_reader u_lcd_id_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .sample_id  (sample_id),
        .lcd_rgb_in (lcd_rgb_in),
        .panel      (panel),
        .id_lcd     (id_lcd)
    );

    lcd_pclk_gen u_lcd_pclk_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .panel    (panel),
        .pclk_en  (pclk_en),
        .lcd_pclk (lcd_pclk)
    );

    lcd_timing #(
        .POS_W (POS_W)
    ) u_lcd_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .pclk_en    (pclk_en),
        .panel      (panel),
        .lcd_hs     (lcd_hs),
        .lcd_vs     (lcd_vs),
        .lcd_de     (lcd_de),
        .data_req   (data_req),
        .pixel_xpos (pixel_xpos),
        .pixel_ypos (pixel_ypos)
    );

    lcd_pixel_path #(
        .PIXEL_W (PIXEL_W)
    ) u_lcd_pixel_path (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .pclk_en     (pclk_en),
        .lcd_de      (lcd_de),
        .pixel_data  (pixel_data),
        .post_rgb    (post_rgb),
        .post_de     (post_de),
        .pre_rgb     (pre_rgb),
        .lcd_rgb_out (lcd_rgb_out),
        .lcd_rgb_oe  (lcd_rgb_oe)
    );

endmodule

// File: testbench/lcd_sva.sv
// ----------------------------------------
// Assertions on startup, pixel clock and line timing
// Bound into the LCD top level
// ----------------------------------------
`timescale 1ns/1ps

module lcd_sva #(
    parameter int POS_W = 11
) (
    input logic             clk,
    input logic             rst_n,
    input logic             sample_id,
    input logic             run,
    input logic             pclk_en,
    input lcd_pkg::panel_e  panel,
    input logic             lcd_rst,
    input logic             lcd_bl,
    input logic             lcd_pclk,
    input logic             lcd_hs,
    input logic             lcd_vs,
    input logic             lcd_de,
    input logic             data_req,
    input logic             lcd_rgb_oe,
    input logic [POS_W-1:0] pixel_xpos
);

    // Failure count, read by the testbench
    int unsigned      fail_cnt = 0;
    int unsigned      since_rst;
    int unsigned      pclk_gap;
    int unsigned      exp_div;
    int unsigned      exp_act;
    logic             pclk_q;
    logic             pclk_seen;
    logic             req_q;
    logic [POS_W-1:0] xpos_q;

    assign exp_div = (panel == lcd_pkg::PANEL_4342) ? 4 : 2;

    always_comb begin
        case (panel)
            lcd_pkg::PANEL_4342: exp_act = 480;
            lcd_pkg::PANEL_7016: exp_act = 1024;
            lcd_pkg::PANEL_1018: exp_act = 1280;
            default:             exp_act = 800;
        endcase
    end

    // ----------------------------------------
    // Reference counters
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_rst <= 0;
            pclk_gap  <= 0;
            pclk_q    <= 1'b0;
            pclk_seen <= 1'b0;
            req_q     <= 1'b0;
            xpos_q    <= '0;
        end else begin
            since_rst <= since_rst + 1;
            pclk_q    <= lcd_pclk;
            // Clocks between pclk rising edges
            if (lcd_pclk && !pclk_q) begin
                pclk_gap  <= 1;
                pclk_seen <= 1'b1;
            end else begin
                pclk_gap <= pclk_gap + 1;
            end
            // Previous pixel period
            if (pclk_en) begin
                req_q  <= data_req;
                xpos_q <= pixel_xpos;
            end
        end
    end

    // ----------------------------------------
    // Startup
    // ----------------------------------------
    a_sample_time: assert property (@(posedge clk) disable iff (!rst_n)
        sample_id |-> since_rst == 16)
        else begin $error("strap sample at cycle %0d", since_rst); fail_cnt++; end

    a_run_time: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(run) |-> since_rst == 80 && lcd_rst && lcd_bl)
        else begin $error("panel reset release at cycle %0d", since_rst); fail_cnt++; end

    a_run_hold: assert property (@(posedge clk) disable iff (!rst_n)
        run |=> run)
        else begin $error("run dropped"); fail_cnt++; end

    // Panel quiet and bus released before video
    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !run |-> !lcd_rgb_oe && !lcd_de && !data_req && lcd_hs && lcd_vs && !lcd_rst && !lcd_bl)
        else begin $error("output active before run"); fail_cnt++; end

    // ----------------------------------------
    // Pixel clock and line timing
    // ----------------------------------------
    a_pclk_period: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(lcd_pclk) && pclk_seen |-> pclk_gap == exp_div)
        else begin $error("pclk period %0d", pclk_gap); fail_cnt++; end

    a_req_leads_de: assert property (@(posedge clk) disable iff (!rst_n)
        pclk_en |-> lcd_de == req_q)
        else begin $error("data_req does not lead lcd_de"); fail_cnt++; end

    a_xpos_start: assert property (@(posedge clk) disable iff (!rst_n)
        pclk_en && data_req && !req_q |-> pixel_xpos == '0)
        else begin $error("xpos %0d at line start", pixel_xpos); fail_cnt++; end

    a_xpos_step: assert property (@(posedge clk) disable iff (!rst_n)
        pclk_en && data_req && req_q |-> pixel_xpos == xpos_q + 1'b1)
        else begin $error("xpos step to %0d", pixel_xpos); fail_cnt++; end

    a_xpos_last: assert property (@(posedge clk) disable iff (!rst_n)
        pclk_en && !data_req && req_q |-> xpos_q == exp_act - 1)
        else begin $error("last xpos %0d", xpos_q); fail_cnt++; end

endmodule

bind lcd lcd_sva #(
    .POS_W (POS_W)
) u_lcd_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .sample_id  (sample_id),
    .run        (run),
    .pclk_en    (pclk_en),
    .panel      (panel),
    .lcd_rst    (lcd_rst),
    .lcd_bl     (lcd_bl),
    .lcd_pclk   (lcd_pclk),
    .lcd_hs     (lcd_hs),
    .lcd_vs     (lcd_vs),
    .lcd_de     (lcd_de),
    .data_req   (data_req),
    .lcd_rgb_oe (lcd_rgb_oe),
    .pixel_xpos (pixel_xpos)
);

// File: testbench/tb_lcd.sv
// ----------------------------------------
// Testbench for the RGB LCD driver
// Strap emulation, pixel source and loopback, three startup tests
// ----------------------------------------
`timescale 1ns/1ps

module tb_lcd;

    localparam int PIXEL_W = 16;
    localparam int POS_W   = 11;
    localparam int SEED    = 32'h2db6_a823;
    // Reset, settle, panel reset and slack per test
    localparam int STARTUP    = 16 + 16 + 64 + 8;
    // One 4342 frame plus a line, 38 lines of 7084, 14 lines of 4342
    localparam int CYC_4342   = 525 * 289 * 4;
    localparam int CYC_7084   = 1056 * 38 * 2;
    localparam int CYC_DFLT   = 525 * 14 * 4;
    localparam int MAX_CYCLES = (CYC_4342 + CYC_7084 + CYC_DFLT + 3 * STARTUP) * 5 / 4;

    logic               clk        = 1'b0;
    logic               rst_n      = 1'b0;
    logic [15:0]        lcd_rgb_in = '0;
    logic [PIXEL_W-1:0] pixel_data = '0;
    logic [PIXEL_W-1:0] post_rgb   = '0;
    logic               post_de    = 1'b0;

    logic               lcd_hs;
    logic               lcd_vs;
    logic               lcd_de;
    logic               lcd_bl;
    logic               lcd_rst;
    logic               lcd_pclk;
    logic [PIXEL_W-1:0] lcd_rgb_out;
    logic               lcd_rgb_oe;
    logic [15:0]        id_lcd;
    logic [PIXEL_W-1:0] pre_rgb;
    logic               data_req;
    logic [POS_W-1:0]   pixel_xpos;
    logic [POS_W-1:0]   pixel_ypos;

    int           cycles = 0;
    int           errors = 0;
    logic [2:0]   strap  = 3'd0;
    logic [15:0]  salt   = '0;
    // Expected geometry of the panel under test
    int           exp_act_w;
    int           exp_h_total;
    int           exp_v_sync;
    int           exp_v_act;
    // Line and frame measurements in pixel periods
    int           de_run;
    int           de_lines;
    int           hs_gap;
    int           vs_run;
    int           vs_falls;
    logic         hs_prev;
    logic         vs_prev;
    // Model of the registered bus pixel
    logic [PIXEL_W-1:0] exp_out;
    logic               exp_oe;
    logic               exp_valid;
    int                 tests_run    = 0;
    int                 tests_failed = 0;

    lcd #(
        .PIXEL_W (PIXEL_W),
        .POS_W   (POS_W)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .lcd_rgb_in  (lcd_rgb_in),
        .lcd_hs      (lcd_hs),
        .lcd_vs      (lcd_vs),
        .lcd_de      (lcd_de),
        .lcd_bl      (lcd_bl),
        .lcd_rst     (lcd_rst),
        .lcd_pclk    (lcd_pclk),
        .lcd_rgb_out (lcd_rgb_out),
        .lcd_rgb_oe  (lcd_rgb_oe),
        .id_lcd      (id_lcd),
        .pixel_data  (pixel_data),
        .pre_rgb     (pre_rgb),
        .post_rgb    (post_rgb),
        .post_de     (post_de),
        .data_req    (data_req),
        .pixel_xpos  (pixel_xpos),
        .pixel_ypos  (pixel_ypos)
    );

    always #20 clk = ~clk;

    // Strap code onto bus bits 4, 10 and 15 with the MSB first
    function automatic logic [15:0] strap_bus(logic [2:0] code);
        logic [15:0] b;
        b     = '0;
        b[4]  = code[2];
        b[10] = code[1];
        b[15] = code[0];
        return b;
    endfunction

    function automatic logic [15:0] id_for_code(logic [2:0] code);
        case (code)
            3'd1:    return 16'h7084;
            3'd2:    return 16'h7016;
            3'd4:    return 16'h4384;
            3'd5:    return 16'h1018;
            default: return 16'h4342;
        endcase
    endfunction

    // Pixel pattern from position scrambled per test
    function automatic logic [PIXEL_W-1:0] pixel_for(logic [POS_W-1:0] x, logic [POS_W-1:0] y);
        return {y[4:0], x[10:0]} ^ salt;
    endfunction

    // ----------------------------------------
    // Input drive
    // ----------------------------------------
    always @(posedge clk) begin
        // Straps until the DUT takes the bus and read back after that
        lcd_rgb_in <= lcd_rgb_oe ? lcd_rgb_out : strap_bus(strap);
        // Inverting loopback as the user processing
        post_rgb   <= ~pre_rgb;
        post_de    <= lcd_de;
        if (uut.pclk_en) begin
            pixel_data <= data_req ? pixel_for(pixel_xpos, pixel_ypos) : '0;
        end
    end

    // ----------------------------------------
    // Pixel path and frame measurement
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            de_run    <= 0;
            de_lines  <= 0;
            hs_gap    <= 0;
            vs_run    <= 0;
            vs_falls  <= 0;
            hs_prev   <= 1'b1;
            vs_prev   <= 1'b1;
            exp_valid <= 1'b0;
        end else begin
            // Tap pixel at the line and pixel position counted here
            assert (pre_rgb == (lcd_de ? pixel_for(POS_W'(de_run), POS_W'(de_lines))
                                       : '0)) else begin
                $display("mismatch at %0t: pre_rgb %h at pixel %0d of line %0d",
                         $time, pre_rgb, de_run, de_lines);
                errors++;
            end
            if (uut.pclk_en) begin
                // Requested line numbered from the first active line
                if (data_req) begin
                    assert (pixel_ypos == POS_W'(de_lines)) else begin
                        $display("mismatch at %0t: pixel_ypos %0d, expected %0d",
                                 $time, pixel_ypos, de_lines);
                        errors++;
                    end
                end
                if (exp_valid) begin
                    assert (lcd_rgb_out == exp_out) else begin
                        $display("mismatch at %0t: lcd_rgb_out %h, expected %h",
                                 $time, lcd_rgb_out, exp_out);
                        errors++;
                    end
                    assert (lcd_rgb_oe == exp_oe) else begin
                        $display("mismatch at %0t: lcd_rgb_oe %b, expected %b",
                                 $time, lcd_rgb_oe, exp_oe);
                        errors++;
                    end
                end
                exp_out   <= lcd_de ? ~pixel_data : '0;
                exp_oe    <= lcd_de;
                exp_valid <= 1'b1;
                // Active pixels per line
                if (lcd_de) begin
                    de_run <= de_run + 1;
                end else if (de_run != 0) begin
                    assert (de_run == exp_act_w) else begin
                        $display("mismatch at %0t: %0d active pixels in line", $time, de_run);
                        errors++;
                    end
                    de_run   <= 0;
                    de_lines <= de_lines + 1;
                end
                // hs pulse spacing
                if (!lcd_hs && hs_prev) begin
                    if (hs_gap != 0) begin
                        assert (hs_gap == exp_h_total) else begin
                            $display("mismatch at %0t: hs spacing %0d", $time, hs_gap);
                            errors++;
                        end
                    end
                    hs_gap <= 1;
                end else if (hs_gap != 0) begin
                    hs_gap <= hs_gap + 1;
                end
                // vs width and active lines per frame
                if (!lcd_vs) begin
                    vs_run <= vs_run + 1;
                end
                if (!lcd_vs && vs_prev) begin
                    if (vs_falls != 0) begin
                        assert (de_lines == exp_v_act) else begin
                            $display("mismatch at %0t: %0d active lines", $time, de_lines);
                            errors++;
                        end
                    end
                    vs_falls <= vs_falls + 1;
                    de_lines <= 0;
                end
                if (lcd_vs && !vs_prev && vs_run != 0) begin
                    assert (vs_run == exp_v_sync * exp_h_total) else begin
                        $display("mismatch at %0t: vs low for %0d pixels", $time, vs_run);
                        errors++;
                    end
                    vs_run <= 0;
                end
                hs_prev <= lcd_hs;
                vs_prev <= lcd_vs;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no result after %0d clock cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    task automatic apply_reset(input logic [2:0] code);
        @(posedge clk);
        strap <= code;
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // lines == 0 watches one whole frame
    task automatic run_test(input string name, input logic [2:0] code, input int act_w,
                            input int h_total, input int v_sync, input int v_act,
                            input int lines);
        int err0;
        int sva0;
        int t_err;
        int t_sva;
        err0        = errors;
        sva0        = uut.u_lcd_sva.fail_cnt;
        exp_act_w   = act_w;
        exp_h_total = h_total;
        exp_v_sync  = v_sync;
        exp_v_act   = v_act;
        salt        = 16'($urandom);
        apply_reset(code);
        while (!lcd_bl) @(posedge clk);
        assert (id_lcd == id_for_code(code)) else begin
            $display("mismatch at %0t: id_lcd %h, expected %h", $time, id_lcd,
                     id_for_code(code));
            errors++;
        end
        if (lines == 0) begin
            while (vs_falls < 2) @(posedge clk);
        end else begin
            while (de_lines < lines) @(posedge clk);
        end
        t_err = errors - err0;
        t_sva = uut.u_lcd_sva.fail_cnt - sva0;
        tests_run++;
        if (t_err + t_sva != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d mismatches, %0d assertion failures", tests_run, name,
                 (t_err + t_sva == 0) ? "pass" : "fail", t_err, t_sva);
    endtask

    initial begin
        void'($urandom(SEED));
        run_test("strap 0, 4342 full frame", 3'd0, 480, 525, 10, 272, 0);
        run_test("strap 1, 7084 three lines", 3'd1, 800, 1056, 2, 480, 3);
        run_test("strap 6, default panel", 3'd6, 480, 525, 10, 272, 2);
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, uut.u_lcd_sva.fail_cnt);
        if (errors == 0 && uut.u_lcd_sva.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
hw/lcd_pkg.sv
hw/lcd_ctrl.sv
hw/lcd_id_reader.sv
hw/lcd_pclk_gen.sv
hw/lcd_timing.sv
hw/lcd_pixel_path.sv
hw/lcd.sv
testbench/lcd_sva.sv
testbench/tb_lcd.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_lcd
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
